// File: rtl/corebus_fifo.sv
// Synchronous FIFO
`timescale 1ns/1ps

module corebus_fifo #(
  parameter int WIDTH     = 8,
  parameter int DEPTH     = 4,
  parameter int THRESHOLD = DEPTH
)(
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_clear,
  output logic                       o_empty,
  output logic                       o_almost_full,
  output logic                       o_full,
  output logic [$clog2(DEPTH+1)-1:0] o_word_count,
  input  logic                       i_push,
  input  logic [WIDTH-1:0]           i_data,
  input  logic                       i_pop,
  output logic [WIDTH-1:0]           o_data
);
  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]       mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic [COUNT_WIDTH-1:0] count_next;
  logic                   push_en;
  logic                   pop_en;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_WIDTH'(1);
  endfunction

  always_comb begin
    push_en = i_push && !o_full;  // A push into a full FIFO is dropped.
    pop_en  = i_pop && !o_empty;
  end

  always_comb begin
    count_next = count;
    if (push_en && !pop_en) begin
      count_next = count + COUNT_WIDTH'(1);
    end
    else if (pop_en && !push_en) begin
      count_next = count - COUNT_WIDTH'(1);
    end
  end

  // Clear has the same effect as reset and wins over push and pop.
  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else begin
      if (push_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      count         <= '0;
      o_empty       <= 1'b1;
      o_almost_full <= 1'b0;
      o_full        <= 1'b0;
    end
    else begin
      count         <= count_next;
      o_empty       <= count_next == '0;
      o_almost_full <= count_next >= COUNT_WIDTH'(THRESHOLD);
      o_full        <= count_next == COUNT_WIDTH'(DEPTH);
    end
  end

  always_ff @(posedge i_clk) begin
    if (push_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_comb begin
    o_word_count = count;
    o_data       = mem[rd_ptr];  // Only valid while the FIFO is not empty.
  end

endmodule

// File: rtl/corebus_pkg.sv
// Core bus response definitions
package corebus_pkg;

  localparam int RESP_ID_WIDTH   = 4;
  localparam int RESP_DATA_WIDTH = 32;

  // 2'b00 is a plain response, 2'b01 a response with data.
  typedef logic [1:0]                 resp_type_t;
  typedef logic [RESP_ID_WIDTH-1:0]   resp_id_t;
  typedef logic [RESP_DATA_WIDTH-1:0] resp_data_t;

  // Type, ID, error, data and last, in that order from the MSB.
  localparam int RESP_PACKED_WIDTH =
    $bits(resp_type_t) + RESP_ID_WIDTH + 1 + RESP_DATA_WIDTH + 1;

  typedef logic [RESP_PACKED_WIDTH-1:0] resp_word_t;

  typedef enum logic {
    MERGE_IDLE,   // Free to pick a new port.
    MERGE_BURST   // Locked to the granted port until the last beat.
  } merge_state_t;

endpackage

// File: rtl/corebus_response_fifo.sv
// Core bus response FIFO
`timescale 1ns/1ps

module corebus_response_fifo #(
  parameter int DEPTH     = 4,
  parameter int THRESHOLD = DEPTH
)(
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_clear,
  output logic                    o_empty,
  output logic                    o_almost_full,
  output logic                    o_full,
  input  logic                    i_sresp_valid,
  input  corebus_pkg::resp_type_t i_sresp_type,
  input  corebus_pkg::resp_id_t   i_sresp_id,
  input  logic                    i_sresp_error,
  input  corebus_pkg::resp_data_t i_sresp_data,
  input  logic                    i_sresp_last,
  output logic                    o_mresp_accept,
  output logic                    o_sresp_valid,
  output corebus_pkg::resp_type_t o_sresp_type,
  output corebus_pkg::resp_id_t   o_sresp_id,
  output logic                    o_sresp_error,
  output corebus_pkg::resp_data_t o_sresp_data,
  output logic                    o_sresp_last,
  input  logic                    i_mresp_accept
);
  corebus_pkg::resp_word_t in_word;
  corebus_pkg::resp_word_t out_word;

  always_comb begin
    in_word = {i_sresp_type, i_sresp_id, i_sresp_error, i_sresp_data, i_sresp_last};
  end

  always_comb begin
    {o_sresp_type, o_sresp_id, o_sresp_error, o_sresp_data, o_sresp_last} = out_word;
  end

  if (DEPTH >= 1) begin : g_fifo
    always_comb begin
      o_mresp_accept = !o_full;
      o_sresp_valid  = !o_empty;
    end

    corebus_fifo #(
      .WIDTH          (corebus_pkg::RESP_PACKED_WIDTH ),
      .DEPTH          (DEPTH                          ),
      .THRESHOLD      (THRESHOLD                      )
    ) u_fifo (
      .i_clk          (i_clk                          ),
      .i_reset        (i_reset                        ),
      .i_clear        (i_clear                        ),
      .o_empty        (o_empty                        ),
      .o_almost_full  (o_almost_full                  ),
      .o_full         (o_full                         ),
      .o_word_count   (),
      .i_push         (i_sresp_valid                  ),
      .i_data         (in_word                        ),
      .i_pop          (o_sresp_valid && i_mresp_accept),
      .o_data         (out_word                       )
    );
  end
  else begin : g_bypass
    always_comb begin
      o_empty       = 1'b1;
      o_almost_full = 1'b0;
      o_full        = 1'b0;
    end

    // Nothing is stored, so the beat goes straight through.
    always_comb begin
      o_mresp_accept = i_mresp_accept;
      o_sresp_valid  = i_sresp_valid;
      out_word       = in_word;
    end
  end

endmodule

// File: rtl/corebus_response_hub.sv
// Core bus response hub
`timescale 1ns/1ps

module corebus_response_hub #(
  parameter int DEPTH     = 4,
  parameter int THRESHOLD = DEPTH
)(
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_clear,
  input  logic                    i_sresp_valid_0,
  input  corebus_pkg::resp_type_t i_sresp_type_0,
  input  corebus_pkg::resp_id_t   i_sresp_id_0,
  input  logic                    i_sresp_error_0,
  input  corebus_pkg::resp_data_t i_sresp_data_0,
  input  logic                    i_sresp_last_0,
  output logic                    o_mresp_accept_0,
  input  logic                    i_sresp_valid_1,
  input  corebus_pkg::resp_type_t i_sresp_type_1,
  input  corebus_pkg::resp_id_t   i_sresp_id_1,
  input  logic                    i_sresp_error_1,
  input  corebus_pkg::resp_data_t i_sresp_data_1,
  input  logic                    i_sresp_last_1,
  output logic                    o_mresp_accept_1,
  output logic                    o_empty_0,
  output logic                    o_almost_full_0,
  output logic                    o_full_0,
  output logic                    o_empty_1,
  output logic                    o_almost_full_1,
  output logic                    o_full_1,
  output logic                    o_sresp_valid,
  output corebus_pkg::resp_type_t o_sresp_type,
  output corebus_pkg::resp_id_t   o_sresp_id,
  output logic                    o_sresp_error,
  output corebus_pkg::resp_data_t o_sresp_data,
  output logic                    o_sresp_last,
  input  logic                    i_mresp_accept
);
  logic                    fifo_valid_0;
  corebus_pkg::resp_type_t fifo_type_0;
  corebus_pkg::resp_id_t   fifo_id_0;
  logic                    fifo_error_0;
  corebus_pkg::resp_data_t fifo_data_0;
  logic                    fifo_last_0;
  logic                    merge_accept_0;
  logic                    fifo_valid_1;
  corebus_pkg::resp_type_t fifo_type_1;
  corebus_pkg::resp_id_t   fifo_id_1;
  logic                    fifo_error_1;
  corebus_pkg::resp_data_t fifo_data_1;
  logic                    fifo_last_1;
  logic                    merge_accept_1;

  corebus_response_fifo #(
    .DEPTH          (DEPTH          ),
    .THRESHOLD      (THRESHOLD      )
  ) u_fifo_0 (
    .i_clk          (i_clk          ),
    .i_reset        (i_reset        ),
    .i_clear        (i_clear        ),
    .o_empty        (o_empty_0      ),
    .o_almost_full  (o_almost_full_0),
    .o_full         (o_full_0       ),
    .i_sresp_valid  (i_sresp_valid_0),
    .i_sresp_type   (i_sresp_type_0 ),
    .i_sresp_id     (i_sresp_id_0   ),
    .i_sresp_error  (i_sresp_error_0),
    .i_sresp_data   (i_sresp_data_0 ),
    .i_sresp_last   (i_sresp_last_0 ),
    .o_mresp_accept (o_mresp_accept_0),
    .o_sresp_valid  (fifo_valid_0   ),
    .o_sresp_type   (fifo_type_0    ),
    .o_sresp_id     (fifo_id_0      ),
    .o_sresp_error  (fifo_error_0   ),
    .o_sresp_data   (fifo_data_0    ),
    .o_sresp_last   (fifo_last_0    ),
    .i_mresp_accept (merge_accept_0 )
  );

  corebus_response_fifo #(
    .DEPTH          (DEPTH          ),
    .THRESHOLD      (THRESHOLD      )
  ) u_fifo_1 (
    .i_clk          (i_clk          ),
    .i_reset        (i_reset        ),
    .i_clear        (i_clear        ),
    .o_empty        (o_empty_1      ),
    .o_almost_full  (o_almost_full_1),
    .o_full         (o_full_1       ),
    .i_sresp_valid  (i_sresp_valid_1),
    .i_sresp_type   (i_sresp_type_1 ),
    .i_sresp_id     (i_sresp_id_1   ),
    .i_sresp_error  (i_sresp_error_1),
    .i_sresp_data   (i_sresp_data_1 ),
    .i_sresp_last   (i_sresp_last_1 ),
    .o_mresp_accept (o_mresp_accept_1),
    .o_sresp_valid  (fifo_valid_1   ),
    .o_sresp_type   (fifo_type_1    ),
    .o_sresp_id     (fifo_id_1      ),
    .o_sresp_error  (fifo_error_1   ),
    .o_sresp_data   (fifo_data_1    ),
    .o_sresp_last   (fifo_last_1    ),
    .i_mresp_accept (merge_accept_1 )
  );

  corebus_response_merger u_merger (
    .i_clk            (i_clk          ),
    .i_reset          (i_reset        ),
    .i_sresp_valid_0  (fifo_valid_0   ),
    .i_sresp_type_0   (fifo_type_0    ),
    .i_sresp_id_0     (fifo_id_0      ),
    .i_sresp_error_0  (fifo_error_0   ),
    .i_sresp_data_0   (fifo_data_0    ),
    .i_sresp_last_0   (fifo_last_0    ),
    .o_mresp_accept_0 (merge_accept_0 ),
    .i_sresp_valid_1  (fifo_valid_1   ),
    .i_sresp_type_1   (fifo_type_1    ),
    .i_sresp_id_1     (fifo_id_1      ),
    .i_sresp_error_1  (fifo_error_1   ),
    .i_sresp_data_1   (fifo_data_1    ),
    .i_sresp_last_1   (fifo_last_1    ),
    .o_mresp_accept_1 (merge_accept_1 ),
    .o_sresp_valid    (o_sresp_valid  ),
    .o_sresp_type     (o_sresp_type   ),
    .o_sresp_id       (o_sresp_id     ),
    .o_sresp_error    (o_sresp_error  ),
    .o_sresp_data     (o_sresp_data   ),
    .o_sresp_last     (o_sresp_last   ),
    .i_mresp_accept   (i_mresp_accept )
  );

endmodule

// File: rtl/corebus_response_merger.sv
// Core bus response merger
`timescale 1ns/1ps

module corebus_response_merger (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_sresp_valid_0,
  input  corebus_pkg::resp_type_t i_sresp_type_0,
  input  corebus_pkg::resp_id_t   i_sresp_id_0,
  input  logic                    i_sresp_error_0,
  input  corebus_pkg::resp_data_t i_sresp_data_0,
  input  logic                    i_sresp_last_0,
  output logic                    o_mresp_accept_0,
  input  logic                    i_sresp_valid_1,
  input  corebus_pkg::resp_type_t i_sresp_type_1,
  input  corebus_pkg::resp_id_t   i_sresp_id_1,
  input  logic                    i_sresp_error_1,
  input  corebus_pkg::resp_data_t i_sresp_data_1,
  input  logic                    i_sresp_last_1,
  output logic                    o_mresp_accept_1,
  output logic                    o_sresp_valid,
  output corebus_pkg::resp_type_t o_sresp_type,
  output corebus_pkg::resp_id_t   o_sresp_id,
  output logic                    o_sresp_error,
  output corebus_pkg::resp_data_t o_sresp_data,
  output logic                    o_sresp_last,
  input  logic                    i_mresp_accept
);
  corebus_pkg::merge_state_t state;
  logic                      grant_port;  // Port that holds the burst lock.
  logic                      rr_port;     // Port favoured at the next pick.
  logic                      sel_port;
  logic                      transfer;

  // Favoured port first, then the other one if only it is valid.
  always_comb begin
    if (state == corebus_pkg::MERGE_BURST) begin
      sel_port = grant_port;
    end
    else if (rr_port) begin
      sel_port = i_sresp_valid_1 || !i_sresp_valid_0;
    end
    else begin
      sel_port = !i_sresp_valid_0 && i_sresp_valid_1;
    end
  end

  always_comb begin
    if (sel_port) begin
      o_sresp_valid = i_sresp_valid_1;
      o_sresp_type  = i_sresp_type_1;
      o_sresp_id    = i_sresp_id_1;
      o_sresp_error = i_sresp_error_1;
      o_sresp_data  = i_sresp_data_1;
      o_sresp_last  = i_sresp_last_1;
    end
    else begin
      o_sresp_valid = i_sresp_valid_0;
      o_sresp_type  = i_sresp_type_0;
      o_sresp_id    = i_sresp_id_0;
      o_sresp_error = i_sresp_error_0;
      o_sresp_data  = i_sresp_data_0;
      o_sresp_last  = i_sresp_last_0;
    end
  end

  always_comb begin
    o_mresp_accept_0 = i_mresp_accept && !sel_port;
    o_mresp_accept_1 = i_mresp_accept && sel_port;
    transfer         = o_sresp_valid && i_mresp_accept;
  end

  // A single beat counts as a burst of one.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state      <= corebus_pkg::MERGE_IDLE;
      grant_port <= 1'b0;
      rr_port    <= 1'b0;
    end
    else if (transfer) begin
      if (o_sresp_last) begin
        state   <= corebus_pkg::MERGE_IDLE;
        rr_port <= !sel_port;  // Hand priority to the other port.
      end
      else begin
        state      <= corebus_pkg::MERGE_BURST;
        grant_port <= sel_port;
      end
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the response hub testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f verilog.f --top-module corebus_response_hub_tb \
  -o corebus_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/corebus_sim > sim.log 2>&1
grep -q ">>> FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q ">>> PASS" sim.log && echo "Simulation passed" || { echo "No result in sim.log"; exit 1; }

// File: tests/corebus_response_hub_tb.sv
// Response hub testbench
`timescale 1ns/1ps

module corebus_response_hub_tb;
  logic clk;
  logic i_reset, i_clear, i_mresp_accept;
  logic i_sresp_valid_0, i_sresp_error_0, i_sresp_last_0, o_mresp_accept_0;
  logic i_sresp_valid_1, i_sresp_error_1, i_sresp_last_1, o_mresp_accept_1;
  logic [1:0] i_sresp_type_0, i_sresp_type_1, o_sresp_type;
  logic [3:0] i_sresp_id_0, i_sresp_id_1, o_sresp_id;
  logic [31:0] i_sresp_data_0, i_sresp_data_1, o_sresp_data;
  logic o_empty_0, o_almost_full_0, o_full_0, o_empty_1, o_almost_full_1, o_full_1;
  logic o_sresp_valid, o_sresp_error, o_sresp_last;

  integer seed = 32'h6cf4ce82;
  int check_errors = 0;
  int other_errors = 0;
  logic [39:0] expected_0[$];
  logic [39:0] expected_1[$];
  int out_source[$];  // Source port of each output beat.
  logic out_last[$];

  corebus_tb_clock u_clock (.o_clk(clk));

  corebus_response_hub #(.DEPTH(4), .THRESHOLD(3)) i_dut (
    .i_clk(clk), .i_reset(i_reset), .i_clear(i_clear),
    .i_sresp_valid_0(i_sresp_valid_0), .i_sresp_type_0(i_sresp_type_0),
    .i_sresp_id_0(i_sresp_id_0), .i_sresp_error_0(i_sresp_error_0),
    .i_sresp_data_0(i_sresp_data_0), .i_sresp_last_0(i_sresp_last_0),
    .o_mresp_accept_0(o_mresp_accept_0),
    .i_sresp_valid_1(i_sresp_valid_1), .i_sresp_type_1(i_sresp_type_1),
    .i_sresp_id_1(i_sresp_id_1), .i_sresp_error_1(i_sresp_error_1),
    .i_sresp_data_1(i_sresp_data_1), .i_sresp_last_1(i_sresp_last_1),
    .o_mresp_accept_1(o_mresp_accept_1),
    .o_empty_0(o_empty_0), .o_almost_full_0(o_almost_full_0), .o_full_0(o_full_0),
    .o_empty_1(o_empty_1), .o_almost_full_1(o_almost_full_1), .o_full_1(o_full_1),
    .o_sresp_valid(o_sresp_valid), .o_sresp_type(o_sresp_type), .o_sresp_id(o_sresp_id),
    .o_sresp_error(o_sresp_error), .o_sresp_data(o_sresp_data),
    .o_sresp_last(o_sresp_last), .i_mresp_accept(i_mresp_accept)
  );

  task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                         input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
      check_errors++;
    end
  endtask

  // The top ID bit tells which port an output beat came from.
  always @(posedge clk) begin
    logic [39:0] got;
    logic [39:0] want;
    if (o_sresp_valid && i_mresp_accept) begin
      got = {o_sresp_type, o_sresp_id, o_sresp_error, o_sresp_data, o_sresp_last};
      out_source.push_back(int'(o_sresp_id[3]));
      out_last.push_back(o_sresp_last);
      if (o_sresp_id[3] ? expected_1.size() == 0 : expected_0.size() == 0) begin
        $display("Unexpected output beat with ID %0d at %0t", o_sresp_id, $time);
        other_errors++;
      end
      else begin
        want = o_sresp_id[3] ? expected_1.pop_front() : expected_0.pop_front();
        compare(64'(got), 64'(want), "output beat fields");
      end
    end
  end

  task automatic drive_port(input int port, input logic valid, input logic [39:0] word);
    if (port == 0) begin
      i_sresp_valid_0 = valid;
      {i_sresp_type_0, i_sresp_id_0, i_sresp_error_0, i_sresp_data_0, i_sresp_last_0} = word;
    end
    else begin
      i_sresp_valid_1 = valid;
      {i_sresp_type_1, i_sresp_id_1, i_sresp_error_1, i_sresp_data_1, i_sresp_last_1} = word;
    end
  endtask

  // Leaves valid high, so back to back beats have no gap.
  task automatic send_beat(input int port, input logic [3:0] id, input logic last);
    logic [31:0] data;
    logic [39:0] word;
    int waited;
    data = $random(seed);
    word = {data[1:0] == 2'b00 ? 2'b00 : 2'b01, id, data[5], data, last};
    waited = 0;
    @(negedge clk);
    drive_port(port, 1'b1, word);
    forever begin
      @(posedge clk);
      if (port == 0 ? o_mresp_accept_0 : o_mresp_accept_1) begin
        if (port == 0) expected_0.push_back(word);
        else expected_1.push_back(word);
        break;
      end
      waited++;
      if (waited > 100) begin
        $display("Port %0d never accepted beat with ID %0d", port, id);
        other_errors++;
        break;
      end
    end
  endtask

  task automatic idle_port(input int port);
    @(negedge clk);
    drive_port(port, 1'b0, '0);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while ((expected_0.size() != 0 || expected_1.size() != 0) && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (waited >= 200) begin
      $display("Output did not drain the expected beats in time");
      other_errors++;
    end
  endtask

  task automatic check_reset_state();
    compare(64'(o_empty_0), 64'(1), "reset o_empty_0");
    compare(64'(o_empty_1), 64'(1), "reset o_empty_1");
    compare(64'({o_full_0, o_full_1, o_almost_full_0, o_almost_full_1}), 64'(0),
            "reset full and almost-full flags");
    compare(64'(o_sresp_valid), 64'(0), "reset o_sresp_valid");
    compare(64'({o_mresp_accept_0, o_mresp_accept_1}), 64'(3), "reset input accepts");
  endtask

  task automatic stream_single_port();
    i_mresp_accept = 1'b1;
    for (int i = 0; i < 8; i++) send_beat(0, 4'(i), 1'b1);
    idle_port(0);
    wait_drained();
  endtask

  task automatic fill_and_drain();
    @(negedge clk);
    i_mresp_accept = 1'b0;
    for (int i = 0; i < 4; i++) begin
      send_beat(1, 4'(8 + i), 1'b1);
      @(negedge clk);
      drive_port(1, 1'b0, '0);
      compare(64'(o_almost_full_1), 64'(i >= 2), "almost-full while filling");
      compare(64'(o_full_1), 64'(i == 3), "full while filling");
    end
    compare(64'(o_mresp_accept_1), 64'(0), "input accept when full");
    // A fifth beat must wait while the FIFO is full.
    drive_port(1, 1'b1, {2'b01, 4'd12, 1'b0, 32'h0000_5a5a, 1'b1});
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      compare(64'(o_mresp_accept_1), 64'(0), "accept stays low when full");
    end
    idle_port(1);
    compare(64'(expected_1.size()), 64'(4), "beats accepted under back-pressure");
    i_mresp_accept = 1'b1;
    wait_drained();
    @(negedge clk);
    compare(64'({o_empty_1, o_almost_full_1, o_full_1}), 64'(3'b100), "flags after drain");
  endtask

  task automatic interleave_bursts();
    out_source.delete();
    out_last.delete();
    fork
      begin
        for (int i = 0; i < 3; i++) send_beat(0, 4'(i), i == 2);
        idle_port(0);
      end
      begin
        for (int i = 0; i < 3; i++) send_beat(1, 4'(8 + i), i == 2);
        idle_port(1);
      end
    join
    wait_drained();
    compare(64'(out_source.size()), 64'(6), "burst beat count");
    for (int i = 0; i < out_source.size() && i < 6; i++) begin
      compare(64'(out_source[i]), 64'(i / 3), "burst source");
      compare(64'(out_last[i]), 64'(i % 3 == 2), "burst last position");
    end
  endtask

  task automatic alternate_ports();
    @(negedge clk);
    i_mresp_accept = 1'b0;
    out_source.delete();
    fork
      begin
        for (int i = 0; i < 3; i++) send_beat(0, 4'(4 + i), 1'b1);
        idle_port(0);
      end
      begin
        for (int i = 0; i < 3; i++) send_beat(1, 4'(12 + i), 1'b1);
        idle_port(1);
      end
    join
    i_mresp_accept = 1'b1;
    wait_drained();
    compare(64'(out_source.size()), 64'(6), "round-robin beat count");
    for (int i = 1; i < out_source.size(); i++) begin
      compare(64'(out_source[i] != out_source[i-1]), 64'(1), "alternating source");
    end
  endtask

  task automatic clear_fifos();
    @(negedge clk);
    i_mresp_accept = 1'b0;
    fork
      begin
        send_beat(0, 4'(1), 1'b1);
        send_beat(0, 4'(2), 1'b1);
        idle_port(0);
      end
      begin
        send_beat(1, 4'(9), 1'b1);
        send_beat(1, 4'(10), 1'b1);
        idle_port(1);
      end
    join
    compare(64'({o_empty_0, o_empty_1}), 64'(0), "o_empty before clear");
    compare(64'(o_sresp_valid), 64'(1), "o_sresp_valid before clear");
    i_clear = 1'b1;
    @(negedge clk);
    i_clear = 1'b0;
    expected_0.delete();
    expected_1.delete();
    compare(64'({o_empty_0, o_empty_1}), 64'(3), "o_empty after clear");
    compare(64'(o_sresp_valid), 64'(0), "o_sresp_valid after clear");
    i_mresp_accept = 1'b1;
    send_beat(0, 4'(3), 1'b1);
    idle_port(0);
    send_beat(1, 4'(11), 1'b1);
    idle_port(1);
    wait_drained();
  endtask

  initial begin
    #20000;
    $display("Watchdog expired, the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    i_reset = 1'b1;
    i_clear = 1'b0;
    i_mresp_accept = 1'b0;
    drive_port(0, 1'b0, '0);
    drive_port(1, 1'b0, '0);
    repeat (16) @(negedge clk);
    i_reset = 1'b0;
    @(negedge clk);
    check_reset_state();
    stream_single_port();
    fill_and_drain();
    interleave_bursts();
    alternate_ports();
    clear_fifos();
    repeat (4) @(negedge clk);
    $display("Errors: %0d check, %0d other", check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end
    else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: tests/corebus_tb_clock.sv
// Testbench clock generator
`timescale 1ns/1ps

module corebus_tb_clock #(
  parameter int HALF_PERIOD = 5
)(
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always begin
    #HALF_PERIOD o_clk = !o_clk;  // 10 ns period at the default.
  end

endmodule

// File: verilog.f
rtl/corebus_pkg.sv
rtl/corebus_fifo.sv
rtl/corebus_response_fifo.sv
rtl/corebus_response_merger.sv
rtl/corebus_response_hub.sv
tests/corebus_tb_clock.sv
tests/corebus_response_hub_tb.sv
